//--- dv/tb_addrgen.sv
/*
  Testbench for the vector address generator. Sends unit-stride, strided and
  misaligned requests and models the AR/AW sequence each one should produce.
  Checks every bus request and every popped descriptor against that model.
*/
`timescale 1ns/1ps

module tb_addrgen import addrgen_pkg::*; ();

  localparam int unsigned     DataBytes  = 8;
  localparam int unsigned     QueueDepth = 4;
  // Longest test moves 600 beats at about half throughput, so this is a wide margin
  localparam int              TimeoutCycles = 20000;
  localparam longint unsigned BusBytes   = 64'(DataBytes);
  localparam longint unsigned PageBytes  = 64'd1 << PageBits;
  localparam longint unsigned BurstBytes = 64'(MaxBurstBeats) * BusBytes;
  localparam logic [2:0]      BusSize    = 3'($clog2(DataBytes));

  logic     clk_i;
  logic     rst_ni;
  mem_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  logic     ack_o;
  logic     error_o;
  logic     core_st_pending_i;
  ax_req_t  ar_o;
  logic     ar_valid_o;
  logic     ar_ready_i = 1'b0;
  ax_req_t  aw_o;
  logic     aw_valid_o;
  logic     aw_ready_i = 1'b0;
  ax_req_t  ldst_req_o;
  logic     ldst_req_valid_o;
  logic     ldst_req_ready_i = 1'b0;

  // Reference model state
  ax_req_t     exp_q[$];
  ax_req_t     mirror_q[$];
  logic [15:0] lfsr_q = 16'd50;
  string       test_name;
  int          cycle_cnt = 0;
  int          accept_cycle = 0;
  logic        busy = 1'b0;
  logic        exp_error = 1'b0;
  logic        hold_check;
  logic        ldst_hold;
  logic        ar_hold = 1'b0;
  logic        aw_hold = 1'b0;
  ax_req_t     ar_prev = '0;
  ax_req_t     aw_prev = '0;

  addrgen_top #(
    .DataBytes (DataBytes ),
    .QueueDepth(QueueDepth)
  ) i_addrgen_top (
    .clk_i            (clk_i            ),
    .rst_ni           (rst_ni           ),
    .req_i            (req_i            ),
    .req_valid_i      (req_valid_i      ),
    .req_ready_o      (req_ready_o      ),
    .ack_o            (ack_o            ),
    .error_o          (error_o          ),
    .core_st_pending_i(core_st_pending_i),
    .ar_o             (ar_o             ),
    .ar_valid_o       (ar_valid_o       ),
    .ar_ready_i       (ar_ready_i       ),
    .aw_o             (aw_o             ),
    .aw_valid_o       (aw_valid_o       ),
    .aw_ready_i       (aw_ready_i       ),
    .ldst_req_o       (ldst_req_o       ),
    .ldst_req_valid_o (ldst_req_valid_o ),
    .ldst_req_ready_i (ldst_req_ready_i )
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic fail_now(string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_ax(string what, ax_req_t exp, ax_req_t act);
    assert (act == exp) else begin
      fail_now($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  // Expected AR/AW sequence of one accepted request
  task automatic model_request(mem_req_t req);
    longint unsigned addr;
    longint unsigned stop;
    longint unsigned start;
    longint unsigned limit;
    ax_req_t         ax;
    ax.is_load = (req.op == VLE) || (req.op == VLSE);
    if ((req.op == VLE) || (req.op == VSE)) begin
      addr = 64'(req.addr);
      stop = addr + (64'(req.len) << req.vew);
      while (addr < stop) begin
        // From the bus word of addr to the nearest of data end, burst cap and page end
        start = addr - (addr % BusBytes);
        limit = (stop + BusBytes - 64'd1) / BusBytes * BusBytes;
        if (start + BurstBytes < limit) begin
          limit = start + BurstBytes;
        end
        if ((addr / PageBytes + 64'd1) * PageBytes < limit) begin
          limit = (addr / PageBytes + 64'd1) * PageBytes;
        end
        ax.addr = addr_t'(addr);
        ax.len  = 8'((limit - start) / BusBytes - 64'd1);
        ax.size = BusSize;
        exp_q.push_back(ax);
        addr = limit;
      end
    end else begin
      // One element per request
      for (int unsigned k = 0; k < 32'(req.len); k++) begin
        ax.addr = req.addr + addr_t'(k) * req.stride;
        ax.len  = '0;
        ax.size = {1'b0, req.vew};
        exp_q.push_back(ax);
      end
    end
  endtask

  task automatic take_request(string chan, ax_req_t act);
    if (exp_q.size() == 0) begin
      fail_now($sformatf("Unexpected %s request in test %s", chan, test_name));
    end else begin
      assert (act.is_load == (chan == "AR")) else
        fail_now($sformatf("%s request of the wrong direction in test %s", chan, test_name));
      check_ax(chan, exp_q.pop_front(), act);
      mirror_q.push_back(act);
    end
  endtask

  task automatic send_request(string name, mem_op_e op, addr_t addr, vlen_t len,
                              stride_t stride, vew_e vew);
    test_name = name;
    @(negedge clk_i);
    req_i.op     = op;
    req_i.addr   = addr;
    req_i.len    = len;
    req_i.stride = stride;
    req_i.vew    = vew;
    req_valid_i  = 1'b1;
    do @(negedge clk_i); while (!busy);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_ack();
    while (busy) begin
      @(negedge clk_i);
    end
  endtask

  task automatic drain_queue();
    while (ldst_req_valid_o) begin
      @(negedge clk_i);
    end
    assert ((mirror_q.size() == 0) && (exp_q.size() == 0)) else
      fail_now($sformatf("Requests left over after test %s", test_name));
  endtask

  // Changed right after a rising edge so the ready driver sees it cleanly
  task automatic set_ldst_hold(logic value);
    @(posedge clk_i);
    ldst_hold = value;
  endtask

  ////////////////////////////////////////
  // Ready drivers, falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    lfsr_q = lfsr_next(lfsr_q);
    ar_ready_i = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    aw_ready_i = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    ldst_req_ready_i = lfsr_q[0] && !ldst_hold;
  end

  ////////////////////////////////////////
  // Monitor and checks, rising edge
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt++;
      if (cycle_cnt >= TimeoutCycles) begin
        fail_now("Timeout, the address generator stopped making progress");
      end
      // Front end takes nothing new until the ack
      if (busy) begin
        assert (!req_ready_o) else
          fail_now($sformatf("Request ready before the ack in test %s", test_name));
      end
      if (req_valid_i && req_ready_o) begin
        busy         = 1'b1;
        accept_cycle = cycle_cnt;
        exp_error    = ((req_i.addr % (32'd1 << req_i.vew)) != 32'd0);
        if (!exp_error) begin
          model_request(req_i);
        end
      end
      if (ar_valid_o || aw_valid_o) begin
        assert (busy && (cycle_cnt >= accept_cycle + 2)) else
          fail_now("Address request raised sooner than two cycles after acceptance");
        assert (!hold_check) else
          fail_now("Address request raised while a scalar store is pending");
        assert (!(ar_valid_o && aw_valid_o)) else
          fail_now("AR and AW valid in the same cycle");
        // Direction may only change once the queue has drained
        assert (!ldst_req_valid_o || (ldst_req_o.is_load == ar_valid_o)) else
          fail_now("Request raised against queued descriptors of the other direction");
      end
      if (ar_hold) begin
        assert (ar_valid_o && (ar_o == ar_prev)) else
          fail_now("AR request dropped or changed before ready");
      end
      if (aw_hold) begin
        assert (aw_valid_o && (aw_o == aw_prev)) else
          fail_now("AW request dropped or changed before ready");
      end
      ar_hold = ar_valid_o && !ar_ready_i;
      aw_hold = aw_valid_o && !aw_ready_i;
      ar_prev = ar_o;
      aw_prev = aw_o;
      if (ar_valid_o && ar_ready_i) begin
        take_request("AR", ar_o);
      end
      if (aw_valid_o && aw_ready_i) begin
        take_request("AW", aw_o);
      end
      if (ldst_req_valid_o && ldst_req_ready_i) begin
        if (mirror_q.size() == 0) begin
          fail_now("Descriptor popped with no bus request behind it");
        end else begin
          check_ax("descriptor", mirror_q.pop_front(), ldst_req_o);
        end
      end
      if (error_o && !ack_o) begin
        fail_now("Error pulse without an acknowledge");
      end
      if (ack_o) begin
        assert (busy) else fail_now("Acknowledge without an accepted request");
        assert (error_o == exp_error) else
          fail_now($sformatf("ERR %s error expected %0b actual %0b",
                             test_name, exp_error, error_o));
        if (error_o) begin
          assert (cycle_cnt == accept_cycle + 1) else
            fail_now($sformatf("ERR %s error ack cycle expected %0d actual %0d",
                               test_name, accept_cycle + 1, cycle_cnt));
        end
        assert (exp_q.size() == 0) else
          fail_now($sformatf("Acknowledge in test %s with %0d requests missing",
                             test_name, exp_q.size()));
        busy = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    req_i             = '0;
    req_valid_i       = 1'b0;
    core_st_pending_i = 1'b0;
    hold_check        = 1'b0;
    ldst_hold         = 1'b0;
    test_name         = "reset";
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (req_ready_o && !ack_o && !error_o && !ar_valid_o && !aw_valid_o
            && !ldst_req_valid_o) else
      fail_now("Outputs not idle after reset");

    // Single burst, then one starting inside a bus word
    send_request("unit_load", VLE, 32'h0000_1000, 16'd16, '0, EW32);
    wait_ack();
    send_request("unit_load_offset", VLE, 32'h0000_7006, 16'd10, '0, EW16);
    wait_ack();

    // Page split, then 256-beat split
    send_request("page_cross_store", VSE, 32'h0000_2FC0, 16'd32, '0, EW32);
    wait_ack();
    send_request("long_load", VLE, 32'h0002_0000, 16'd600, '0, EW64);
    wait_ack();

    send_request("strided_store", VSSE, 32'h1000_0002, 16'd5, 32'd24, EW16);
    wait_ack();

    // Refused request must leave bus and queue untouched
    drain_queue();
    send_request("misaligned", VLE, 32'h0000_1002, 16'd4, '0, EW32);
    wait_ack();

    // Scalar store pending from before the request
    @(negedge clk_i);
    core_st_pending_i = 1'b1;
    hold_check        = 1'b1;
    send_request("store_pending", VLE, 32'h0000_4000, 16'd8, '0, EW64);
    repeat (20) @(negedge clk_i);
    core_st_pending_i = 1'b0;
    hold_check        = 1'b0;
    wait_ack();

    // Load behind unpopped store descriptors
    drain_queue();
    set_ldst_hold(1'b1);
    send_request("order_store", VSSE, 32'h0000_5000, 16'd3, 32'd16, EW32);
    wait_ack();
    send_request("order_load", VLSE, 32'h0000_6001, 16'd4, 32'd3, EW8);
    repeat (10) @(negedge clk_i);
    set_ldst_hold(1'b0);
    wait_ack();
    drain_queue();

    $display("All tests passed");
    $finish;
  end

endmodule

//--- flist.f
src/addrgen_pkg.sv
src/addrgen_burst_calc.sv
src/addrgen_cmd_fsm.sv
src/addrgen_ax_fsm.sv
src/addrgen_desc_fifo.sv
src/addrgen_top.sv
dv/tb_addrgen.sv

//--- run_sim.sh
#!/bin/sh
# Compile the address generator testbench with Verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f flist.f --top-module tb_addrgen -Mdir obj_dir \
  && { out=$(./obj_dir/Vtb_addrgen 2>&1); echo "$out"; echo "$out" | grep -q "All tests passed"; } \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

//--- src/addrgen_ax_fsm.sv
/*
  Request generator. Turns one command into AR or AW requests, full-width
  bursts for unit-stride and single beats for strided accesses, and pushes
  a copy of each accepted request into the descriptor queue.
*/
`timescale 1ns/1ps

module addrgen_ax_fsm import addrgen_pkg::*; #(
  parameter int unsigned DataBytes = 8
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Command from the front end
  input  ag_cmd_t cmd_i,
  input  logic    cmd_valid_i,
  output logic    cmd_done_o,
  // Scalar store still in flight in the core
  input  logic    core_st_pending_i,
  // Bus address channels
  output ax_req_t ar_o,
  output logic    ar_valid_o,
  input  logic    ar_ready_i,
  output ax_req_t aw_o,
  output logic    aw_valid_o,
  input  logic    aw_ready_i,
  // Descriptor queue
  input  logic    q_full_i,
  input  logic    q_empty_i,
  input  logic    q_head_is_load_i,
  output logic    q_push_o,
  output ax_req_t q_data_o
);

  localparam int unsigned DwLog = $clog2(DataBytes);

  typedef enum logic [1:0] {
    IDLE,
    WAITING,
    REQUESTING
  } state_e;

  state_e     state_q;
  state_e     state_d;
  // Current address and remaining elements live in here
  ag_cmd_t    cur_q;
  ag_cmd_t    cur_d;
  logic [8:0] beats;
  addr_t      next_addr;
  vlen_t      consumed;
  vlen_t      len_left;
  ax_req_t    ax_req;
  logic       order_ok;
  logic       issue;
  logic       ax_ready;
  logic       handshake;

  addrgen_burst_calc #(
    .DataBytes(DataBytes)
  ) i_burst_calc (
    .addr_i     (cur_q.addr),
    .len_i      (cur_q.len ),
    .vew_i      (cur_q.vew ),
    .beats_o    (beats     ),
    .next_addr_o(next_addr ),
    .consumed_o (consumed  )
  );

  ////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////

  always_comb begin
    ax_req.addr    = cur_q.addr;
    ax_req.is_load = cur_q.is_load;
    if (cur_q.is_burst) begin
      ax_req.len  = 8'(beats - 9'd1);
      ax_req.size = 3'(DwLog);
    end else begin
      // One element per request
      ax_req.len  = '0;
      ax_req.size = {1'b0, cur_q.vew};
    end
  end

  // Switch direction only once the queue has drained the other one
  assign order_ok = q_empty_i || (q_head_is_load_i == cur_q.is_load);
  assign issue    = (state_q == REQUESTING) && order_ok && !q_full_i;

  assign ar_valid_o = issue && cur_q.is_load;
  assign aw_valid_o = issue && !cur_q.is_load;
  assign ar_o       = ax_req;
  assign aw_o       = ax_req;

  assign ax_ready  = cur_q.is_load ? ar_ready_i : aw_ready_i;
  assign handshake = issue && ax_ready;

  // Every accepted request becomes a descriptor
  assign q_push_o = handshake;
  assign q_data_o = ax_req;

  // Elements left after this request
  assign len_left   = cur_q.is_burst ? (cur_q.len - consumed) : (cur_q.len - vlen_t'(1));
  assign cmd_done_o = handshake && (len_left == '0);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cur_d   = cur_q;
    case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          cur_d   = cmd_i;
          state_d = core_st_pending_i ? WAITING : REQUESTING;
        end
      end
      WAITING: begin
        // Hold off until the scalar store is out
        if (!core_st_pending_i) begin
          state_d = REQUESTING;
        end
      end
      REQUESTING: begin
        if (handshake) begin
          cur_d.len  = len_left;
          // Bursts continue at the next aligned word, strided by one stride
          cur_d.addr = cur_q.is_burst ? next_addr : (cur_q.addr + cur_q.stride);
          if (len_left == '0) begin
            state_d = IDLE;
          end else if (core_st_pending_i) begin
            state_d = WAITING;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
  end

  // Loads and stores never share a cycle on the bus
  a_one_channel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o));

  // Queue must have room for every accepted request
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    q_push_o |-> !q_full_i);

  // Stalled request stays up and unchanged until ready
  a_hold_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue && !ax_ready) |=> (issue && $stable(ax_req)));

endmodule

//--- src/addrgen_burst_calc.sv
/*
  Combinational size calculator for one unit-stride burst. Given the current
  address and the remaining elements it returns the beat count, the aligned
  start of the following burst and the number of elements covered.
*/
`timescale 1ns/1ps

module addrgen_burst_calc import addrgen_pkg::*; #(
  parameter int unsigned DataBytes = 8
) (
  input  addr_t      addr_i,
  input  vlen_t      len_i,
  input  vew_e       vew_i,
  output logic [8:0] beats_o,
  output addr_t      next_addr_o,
  output vlen_t      consumed_o
);

  localparam int unsigned DwLog = $clog2(DataBytes);

  // One extra bit so a page end at the top of memory does not wrap
  typedef logic [$bits(addr_t):0] ext_addr_t;

  localparam ext_addr_t WordMask = ~ext_addr_t'(DataBytes - 1);

  ext_addr_t addr_ext;
  ext_addr_t start;
  ext_addr_t data_bytes;
  ext_addr_t data_end;
  ext_addr_t max_end;
  ext_addr_t page_end;
  ext_addr_t span_end;
  ext_addr_t span_bytes;
  ext_addr_t elem_bytes;
  ext_addr_t elem_cnt;

  always_comb begin
    addr_ext = {1'b0, addr_i};
    // Burst starts on the bus word holding the first element
    start    = addr_ext & WordMask;

    ////////////////////////////////////////
    // Candidate ends, all exclusive
    ////////////////////////////////////////

    // Word after the last byte still to transfer
    data_bytes = ext_addr_t'(len_i) << vew_i;
    data_end   = ((addr_ext + data_bytes - ext_addr_t'(1)) & WordMask)
                 + ext_addr_t'(DataBytes);
    // Longest burst the bus allows
    max_end    = start + (ext_addr_t'(MaxBurstBeats) << DwLog);
    // Base of the next page
    page_end   = ((addr_ext >> PageBits) + ext_addr_t'(1)) << PageBits;

    // Earliest of the three
    span_end = data_end;
    if (max_end < span_end) begin
      span_end = max_end;
    end
    if (page_end < span_end) begin
      span_end = page_end;
    end

    span_bytes  = span_end - start;
    beats_o     = 9'(span_bytes >> DwLog);
    next_addr_o = addr_t'(span_end);

    // Elements from the real start on, the last burst may overshoot
    elem_bytes = span_end - addr_ext;
    elem_cnt   = elem_bytes >> vew_i;
    if (elem_cnt >= ext_addr_t'(len_i)) begin
      consumed_o = len_i;
    end else begin
      consumed_o = vlen_t'(elem_cnt);
    end
  end

endmodule

//--- src/addrgen_cmd_fsm.sv
/*
  Front end of the address generator. Takes one memory request at a time,
  refuses bases not aligned to the element width and otherwise hands a
  command to the request generator, acknowledging once it is fully issued.
*/
`timescale 1ns/1ps

module addrgen_cmd_fsm import addrgen_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Request side
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  // Command to the request generator
  output ag_cmd_t  cmd_o,
  output logic     cmd_valid_o,
  input  logic     cmd_done_i,
  // Completion pulses
  output logic     ack_o,
  output logic     error_o
);

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ISSUE
  } state_e;

  state_e   state_q;
  state_e   state_d;
  mem_req_t req_q;
  logic     misaligned;

  // Any address bit below the element size set
  function automatic logic is_misaligned(addr_t addr, vew_e vew);
    addr_t mask;
    mask = (addr_t'(1) << vew) - addr_t'(1);
    return |(addr & mask);
  endfunction

  // New requests only while idle
  assign req_ready_o = (state_q == IDLE);
  assign misaligned  = is_misaligned(req_q.addr, req_q.vew);

  ////////////////////////////////////////
  // Command
  ////////////////////////////////////////

  always_comb begin
    cmd_o.addr     = req_q.addr;
    cmd_o.len      = req_q.len;
    cmd_o.stride   = req_q.stride;
    cmd_o.vew      = req_q.vew;
    cmd_o.is_load  = req_q.op inside {VLE, VLSE};
    cmd_o.is_burst = req_q.op inside {VLE, VSE};
  end

  // Held until the last bus request handshakes
  assign cmd_valid_o = (state_q == ISSUE);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    ack_o   = 1'b0;
    error_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          // Refused, nothing reaches the bus
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = IDLE;
        end else if (req_q.len == '0) begin
          // Empty vector, done right away
          ack_o   = 1'b1;
          state_d = IDLE;
        end else begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (cmd_done_i) begin
          ack_o   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  // No completion without an accepted request
  a_no_ack_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> (state_q != IDLE));

  // Generator only finishes a command that is being presented
  a_done_in_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_i |-> (state_q == ISSUE));

endmodule

//--- src/addrgen_desc_fifo.sv
/*
  Descriptor queue towards the load and store units. Circular buffer with
  registered full and empty flags, the head entry is shown on data_o.
*/
`timescale 1ns/1ps

module addrgen_desc_fifo import addrgen_pkg::*; #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  ax_req_t data_i,
  input  logic    pop_i,
  output ax_req_t data_o,
  output logic    full_o,
  output logic    empty_o
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  ax_req_t mem_q [QueueDepth];
  ptr_t    rd_ptr_q;
  ptr_t    wr_ptr_q;
  cnt_t    count_q;

  // Wraps for depths that are not a power of two
  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(QueueDepth - 1)) ? '0 : (ptr + ptr_t'(1));
  endfunction

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == cnt_t'(QueueDepth));
  assign empty_o = (count_q == '0);

  ////////////////////////////////////////
  // Pointers and fill level
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Consumer only pops a descriptor it was shown
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

//--- src/addrgen_pkg.sv
/*
  Shared widths, encodings and request formats of the vector address generator.
  Every block of the unit and the testbench import this package.
*/
package addrgen_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Byte address on the memory bus
  typedef logic [31:0] addr_t;
  // Number of vector elements
  typedef logic [15:0] vlen_t;
  // Byte distance between two strided elements
  typedef logic [31:0] stride_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Element width as log2 of its byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Supported vector memory operations
  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } mem_op_e;

  ////////////////////////////////////////
  // Request formats
  ////////////////////////////////////////

  // Vector memory request from the core
  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    vlen_t   len;
    stride_t stride;
    vew_e    vew;
  } mem_req_t;

  // Checked command for the request generator
  typedef struct packed {
    addr_t   addr;
    vlen_t   len;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    // Unit-stride, issued as incrementing bursts
    logic    is_burst;
  } ag_cmd_t;

  // One AR/AW request, same layout for the load/store descriptor
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic       is_load;
  } ax_req_t;

  // Bursts stay inside a 4 KiB page
  localparam int unsigned PageBits      = 12;
  localparam int unsigned MaxBurstBeats = 256;

endpackage

//--- src/addrgen_top.sv
/*
  Vector memory address generator. Connects the request front end, the
  AR/AW request generator and the descriptor queue for the load/store units.
*/
`timescale 1ns/1ps

module addrgen_top import addrgen_pkg::*; #(
  parameter int unsigned DataBytes  = 8,
  parameter int unsigned QueueDepth = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Vector memory requests
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output logic     ack_o,
  output logic     error_o,
  input  logic     core_st_pending_i,
  // Read address channel
  output ax_req_t  ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  // Write address channel
  output ax_req_t  aw_o,
  output logic     aw_valid_o,
  input  logic     aw_ready_i,
  // Descriptors for the load/store units
  output ax_req_t  ldst_req_o,
  output logic     ldst_req_valid_o,
  input  logic     ldst_req_ready_i
);

  ag_cmd_t cmd;
  logic    cmd_valid;
  logic    cmd_done;
  ax_req_t q_data;
  logic    q_push;
  logic    q_pop;
  logic    q_full;
  logic    q_empty;

  // Queue head is the descriptor output, popped on handshake
  assign ldst_req_valid_o = !q_empty;
  assign q_pop            = ldst_req_valid_o && ldst_req_ready_i;

  addrgen_cmd_fsm i_cmd_fsm (
    .clk_i      (clk_i      ),
    .rst_ni     (rst_ni     ),
    .req_i      (req_i      ),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .cmd_o      (cmd        ),
    .cmd_valid_o(cmd_valid  ),
    .cmd_done_i (cmd_done   ),
    .ack_o      (ack_o      ),
    .error_o    (error_o    )
  );

  addrgen_ax_fsm #(
    .DataBytes(DataBytes)
  ) i_ax_fsm (
    .clk_i            (clk_i            ),
    .rst_ni           (rst_ni           ),
    .cmd_i            (cmd              ),
    .cmd_valid_i      (cmd_valid        ),
    .cmd_done_o       (cmd_done         ),
    .core_st_pending_i(core_st_pending_i),
    .ar_o             (ar_o             ),
    .ar_valid_o       (ar_valid_o       ),
    .ar_ready_i       (ar_ready_i       ),
    .aw_o             (aw_o             ),
    .aw_valid_o       (aw_valid_o       ),
    .aw_ready_i       (aw_ready_i       ),
    .q_full_i         (q_full           ),
    .q_empty_i        (q_empty          ),
    .q_head_is_load_i (ldst_req_o.is_load),
    .q_push_o         (q_push           ),
    .q_data_o         (q_data           )
  );

  addrgen_desc_fifo #(
    .QueueDepth(QueueDepth)
  ) i_desc_fifo (
    .clk_i  (clk_i     ),
    .rst_ni (rst_ni    ),
    .push_i (q_push    ),
    .data_i (q_data    ),
    .pop_i  (q_pop     ),
    .data_o (ldst_req_o),
    .full_o (q_full    ),
    .empty_o(q_empty   )
  );

endmodule
